// ==== Makefile ====
TOP := tb_rv_core_ex

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then \
		echo "Simulation failed."; exit 1; \
	elif ! grep -q "TEST RESULT: PASS" sim.log; then \
		echo "Simulation ended without a result."; exit 1; \
	fi
	@echo "Simulation passed."

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
+incdir+hdl
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_idu.sv
hdl/rv_exu.sv
hdl/rv_core_ex.sv
verif/rv_core_ex_asserts.sv
verif/tb_rv_core_ex.sv

// ==== hdl/rv_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_alu (
    input  rv_pkg::alu_op_t  alu_op,
    input  rv_pkg::br_cond_t br_cond,
    input  wire              is_branch,
    input  rv_pkg::word_t    a,
    input  rv_pkg::word_t    b,
    input  rv_pkg::word_t    c,
    input  rv_pkg::word_t    d,
    output rv_pkg::word_t    result1,
    output logic             cond_true
);

    import rv_pkg::*;

    word_t      sum;
    word_t      diff;
    word_t      slt_res;
    word_t      sltu_res;
    word_t      sra_res;
    logic [4:0] shamt;
    logic       cmp_eq;
    logic       cmp_lt;
    logic       cmp_ltu;
    logic       cmp_hit;

    ////////////////////
    // Primary result.
    ////////////////////
    assign shamt    = b[4:0];
    assign sum      = a + b;
    assign diff     = a - b;
    assign slt_res  = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
    assign sltu_res = {{(`RV_XLEN-1){1'b0}}, a < b};
    assign sra_res  = $signed(a) >>> shamt;

    // One-hot select, so an empty op gives zero.
    assign result1 =
        ({`RV_XLEN{alu_op[`RV_ALU_ADD] | alu_op[`RV_ALU_CMP]}} & sum) |
        ({`RV_XLEN{alu_op[`RV_ALU_SUB]}}  & diff)     |
        ({`RV_XLEN{alu_op[`RV_ALU_SLT]}}  & slt_res)  |
        ({`RV_XLEN{alu_op[`RV_ALU_SLTU]}} & sltu_res) |
        ({`RV_XLEN{alu_op[`RV_ALU_AND]}}  & (a & b))  |
        ({`RV_XLEN{alu_op[`RV_ALU_OR]}}   & (a | b))  |
        ({`RV_XLEN{alu_op[`RV_ALU_XOR]}}  & (a ^ b))  |
        ({`RV_XLEN{alu_op[`RV_ALU_SLL]}}  & (a << shamt)) |
        ({`RV_XLEN{alu_op[`RV_ALU_SRL]}}  & (a >> shamt)) |
        ({`RV_XLEN{alu_op[`RV_ALU_SRA]}}  & sra_res)  |
        ({`RV_XLEN{alu_op[`RV_ALU_LUI]}}  & b);

    ////////////////////
    // Branch compare.
    ////////////////////
    assign cmp_eq  = c == d;
    assign cmp_lt  = $signed(c) < $signed(d);
    assign cmp_ltu = c < d;

    always_comb begin
        case (br_cond)
            3'b000:  cmp_hit = cmp_eq;    // beq.
            3'b001:  cmp_hit = !cmp_eq;   // bne.
            3'b100:  cmp_hit = cmp_lt;
            3'b101:  cmp_hit = !cmp_lt;
            3'b110:  cmp_hit = cmp_ltu;
            3'b111:  cmp_hit = !cmp_ltu;
            default: cmp_hit = 1'b0;
        endcase
    end

    assign cond_true = is_branch && cmp_hit;

endmodule

`default_nettype wire

// ==== hdl/rv_core_ex.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_ex (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 in_valid,
    output logic                in_ready,
    input  rv_pkg::inst_t       inst,
    input  rv_pkg::word_t       pc,
    input  rv_pkg::operand_t    ops,
    input  wire                 lsu_ready,
    output logic                exu_valid,
    output rv_pkg::ex_out_t     ex_out,
    output rv_pkg::word_t       dnpc,
    output logic                ebreak,
    output logic                inst_bad
);

    import rv_pkg::*;

    logic     idu_valid;
    logic     exu_ready;
    decode_t  dec;
    word_t    idu_pc;
    operand_t idu_ops;

    rv_idu u_idu (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst      (inst),
        .pc        (pc),
        .ops       (ops),
        .idu_valid (idu_valid),
        .exu_ready (exu_ready),
        .dec       (dec),
        .pc_q      (idu_pc),
        .ops_q     (idu_ops)
    );

    rv_exu u_exu (
        .clk       (clk),
        .rst       (rst),
        .idu_valid (idu_valid),
        .exu_ready (exu_ready),
        .dec       (dec),
        .pc        (idu_pc),
        .ops       (idu_ops),
        .lsu_ready (lsu_ready),
        .exu_valid (exu_valid),
        .ex_out    (ex_out),
        .dnpc      (dnpc),
        .ebreak    (ebreak),
        .inst_bad  (inst_bad)
    );

endmodule

`default_nettype wire

// ==== hdl/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define RV_XLEN       32
`define RV_ALU_OP_WD  12

// RV32I major opcodes.
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OPIMM   7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_AUIPC   7'b0010111
`define RV_OPC_JAL     7'b1101111
`define RV_OPC_JALR    7'b1100111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_LOAD    7'b0000011
`define RV_OPC_STORE   7'b0100011
`define RV_OPC_SYSTEM  7'b1110011

// Bit positions in the one-hot ALU select.
`define RV_ALU_ADD   0
`define RV_ALU_SUB   1
`define RV_ALU_SLT   2
`define RV_ALU_SLTU  3
`define RV_ALU_AND   4
`define RV_ALU_OR    5
`define RV_ALU_XOR   6
`define RV_ALU_SLL   7
`define RV_ALU_SRL   8
`define RV_ALU_SRA   9
`define RV_ALU_LUI   10
`define RV_ALU_CMP   11

`endif

// ==== hdl/rv_exu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_exu (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 idu_valid,
    output logic                exu_ready,
    input  rv_pkg::decode_t     dec,
    input  rv_pkg::word_t       pc,
    input  rv_pkg::operand_t    ops,
    input  wire                 lsu_ready,
    output logic                exu_valid,
    output rv_pkg::ex_out_t     ex_out,
    output rv_pkg::word_t       dnpc,
    output logic                ebreak,
    output logic                inst_bad
);

    import rv_pkg::*;

    exu_state_t state;
    exu_state_t state_nxt;
    logic       accept;
    logic       finish;

    decode_t    dec_r;
    word_t      pc_r;
    operand_t   ops_r;

    word_t      alu_a;
    word_t      alu_b;
    word_t      alu_res;
    logic       br_taken;
    word_t      snpc;
    word_t      dnpc_d;
    ex_out_t    ex_out_d;

    ////////////////////
    // Control.
    ////////////////////
    assign exu_ready = state == IDLE;
    assign accept    = idu_valid && exu_ready;
    assign finish    = state == BUSY && lsu_ready;

    always_comb begin
        case (state)
            IDLE:    state_nxt = accept ? BUSY : IDLE;
            BUSY:    state_nxt = lsu_ready ? IDLE : BUSY;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst)
            state <= IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec_r <= dec;
            pc_r  <= pc;
            ops_r <= ops;
        end
    end

    ////////////////////
    // Datapath.
    ////////////////////
    assign alu_a = dec_r.src1_is_pc  ? pc_r      : ops_r.src1;
    assign alu_b = dec_r.src2_is_imm ? dec_r.imm : ops_r.src2;

    rv_alu u_alu (
        .alu_op    (dec_r.alu_op),
        .br_cond   (dec_r.br_cond),
        .is_branch (dec_r.is_branch),
        .a         (alu_a),
        .b         (alu_b),
        .c         (ops_r.src1),
        .d         (ops_r.src2),
        .result1   (alu_res),
        .cond_true (br_taken)
    );

    assign snpc   = pc_r + `RV_XLEN'd4;
    assign dnpc_d = dec_r.ecall_en ? ops_r.mtvec :
                    dec_r.mret_en  ? ops_r.mepc  :
                    dec_r.is_jump  ? {alu_res[`RV_XLEN-1:1], 1'b0} :
                    br_taken       ? alu_res     :
                                     snpc;

    assign ex_out_d.result     = dec_r.is_jump ? snpc : alu_res;  // Link address.
    assign ex_out_d.store_data = ops_r.src2;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exu_valid <= 1'b0;
            ex_out    <= '0;
            dnpc      <= '0;
            ebreak    <= 1'b0;
            inst_bad  <= 1'b0;
        end else begin
            exu_valid <= finish;  // One cycle pulse.
            if (finish) begin
                ex_out   <= ex_out_d;
                dnpc     <= dnpc_d;
                ebreak   <= dec_r.ebreak;
                inst_bad <= dec_r.inst_bad;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_idu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module rv_idu (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 in_valid,
    output logic                in_ready,
    input  rv_pkg::inst_t       inst,
    input  rv_pkg::word_t       pc,
    input  rv_pkg::operand_t    ops,
    output logic                idu_valid,
    input  wire                 exu_ready,
    output rv_pkg::decode_t     dec,
    output rv_pkg::word_t       pc_q,
    output rv_pkg::operand_t    ops_q
);

    import rv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    logic       bad;
    decode_t    dec_d;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'b0};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // Shared by OP and OP-IMM; alt picks sub or sra.
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        op = '0;
        case (f3)
            3'b000:  op[alt ? `RV_ALU_SUB : `RV_ALU_ADD] = 1'b1;
            3'b001:  op[`RV_ALU_SLL] = 1'b1;
            3'b010:  op[`RV_ALU_SLT] = 1'b1;
            3'b011:  op[`RV_ALU_SLTU] = 1'b1;
            3'b100:  op[`RV_ALU_XOR] = 1'b1;
            3'b101:  op[alt ? `RV_ALU_SRA : `RV_ALU_SRL] = 1'b1;
            3'b110:  op[`RV_ALU_OR] = 1'b1;
            default: op[`RV_ALU_AND] = 1'b1;
        endcase
        return op;
    endfunction

    ////////////////////
    // Decode.
    ////////////////////
    always_comb begin
        dec_d = '0;
        bad   = 1'b0;
        case (opcode)
            `RV_OPC_OP: begin
                dec_d.alu_op = alu_sel(funct3, funct7[5]);
                bad = !(funct7 == 7'h00 ||
                        (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            `RV_OPC_OPIMM: begin
                dec_d.alu_op      = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
                dec_d.imm         = imm_i;
                dec_d.src2_is_imm = 1'b1;
                if (funct3 == 3'b001)
                    bad = funct7 != 7'h00;
                else if (funct3 == 3'b101)
                    bad = funct7 != 7'h00 && funct7 != 7'h20;
            end
            `RV_OPC_LUI, `RV_OPC_AUIPC: begin
                dec_d.alu_op[(opcode == `RV_OPC_LUI) ? `RV_ALU_LUI : `RV_ALU_ADD] = 1'b1;
                dec_d.imm         = imm_u;
                dec_d.src1_is_pc  = opcode == `RV_OPC_AUIPC;
                dec_d.src2_is_imm = 1'b1;
            end
            `RV_OPC_JAL, `RV_OPC_JALR: begin
                dec_d.alu_op[`RV_ALU_ADD] = 1'b1;
                dec_d.imm         = (opcode == `RV_OPC_JAL) ? imm_j : imm_i;
                dec_d.src1_is_pc  = opcode == `RV_OPC_JAL;
                dec_d.src2_is_imm = 1'b1;
                dec_d.is_jump     = 1'b1;
                bad = opcode == `RV_OPC_JALR && funct3 != 3'b000;
            end
            `RV_OPC_BRANCH: begin
                dec_d.alu_op[`RV_ALU_CMP] = 1'b1;  // Target is pc + imm.
                dec_d.imm         = imm_b;
                dec_d.br_cond     = funct3;
                dec_d.src1_is_pc  = 1'b1;
                dec_d.src2_is_imm = 1'b1;
                dec_d.is_branch   = 1'b1;
                bad = funct3 == 3'b010 || funct3 == 3'b011;
            end
            `RV_OPC_LOAD, `RV_OPC_STORE: begin
                dec_d.alu_op[`RV_ALU_ADD] = 1'b1;
                dec_d.imm         = (opcode == `RV_OPC_LOAD) ? imm_i : imm_s;
                dec_d.src2_is_imm = 1'b1;
                dec_d.is_load     = opcode == `RV_OPC_LOAD;
                dec_d.is_store    = opcode == `RV_OPC_STORE;
                if (opcode == `RV_OPC_LOAD)
                    bad = funct3 == 3'b011 || funct3 == 3'b110 || funct3 == 3'b111;
                else
                    bad = funct3[2] || funct3 == 3'b011;
            end
            `RV_OPC_SYSTEM: begin
                // Only ecall, ebreak and mret; CSR ops fall out as bad.
                case (inst[31:7])
                    25'h0000000: dec_d.ecall_en = 1'b1;
                    25'h0002000: dec_d.ebreak   = 1'b1;
                    25'h0604000: dec_d.mret_en  = 1'b1;
                    default:     bad = 1'b1;
                endcase
            end
            default: bad = 1'b1;
        endcase
        if (bad) begin
            dec_d          = '0;
            dec_d.inst_bad = 1'b1;
        end
    end

    ////////////////////
    // One-entry output register.
    ////////////////////
    assign in_ready = !idu_valid || exu_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            idu_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            idu_valid <= 1'b1;
        end else if (exu_ready) begin
            idu_valid <= 1'b0;  // Taken by execute.
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            dec   <= dec_d;
            pc_q  <= pc;
            ops_q <= ops;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
`default_nettype none

`include "rv_defines.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]      word_t;
    typedef logic [31:0]              inst_t;
    typedef logic [`RV_ALU_OP_WD-1:0] alu_op_t;
    typedef logic [2:0]               br_cond_t;

    ////////////////////
    // Decoder to execute.
    ////////////////////
    typedef struct packed {
        word_t    imm;
        alu_op_t  alu_op;
        br_cond_t br_cond;
        logic     src1_is_pc;
        logic     src2_is_imm;
        logic     is_jump;      // jal or jalr.
        logic     is_branch;
        logic     is_load;
        logic     is_store;
        logic     ecall_en;
        logic     mret_en;
        logic     ebreak;
        logic     inst_bad;
    } decode_t;

    // Register file and CSR reads.
    typedef struct packed {
        word_t src1;
        word_t src2;
        word_t mtvec;
        word_t mepc;
    } operand_t;

    ////////////////////
    // Execute to load-store.
    ////////////////////
    typedef struct packed {
        word_t result;
        word_t store_data;
    } ex_out_t;

    typedef enum logic {
        IDLE,
        BUSY
    } exu_state_t;

endpackage

`default_nettype wire

// ==== verif/rv_core_ex_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_ex_asserts (
    input wire                 clk,
    input wire                 rst,
    input wire                 in_ready,
    input wire                 idu_valid,
    input wire                 exu_ready,
    input wire                 exu_valid,
    input rv_pkg::decode_t     dec,
    input rv_pkg::word_t       idu_pc,
    input rv_pkg::operand_t    idu_ops,
    input rv_pkg::ex_out_t     ex_out,
    input rv_pkg::word_t       dnpc,
    input wire                 ebreak,
    input wire                 inst_bad
);

    valid_pulse: assert property (@(posedge clk) disable iff (!rst)
        exu_valid |=> !exu_valid)
        else $error("exu_valid high for more than one cycle");

    // Decoder entry frozen while execute is busy.
    entry_hold: assert property (@(posedge clk) disable iff (!rst)
        idu_valid && !exu_ready |=>
            idu_valid && $stable(dec) && $stable(idu_pc) && $stable(idu_ops))
        else $error("decoder entry changed while waiting for execute");

    reset_values: assert property (@(posedge clk)
        !rst |-> in_ready && exu_ready && !idu_valid && !exu_valid &&
                 ex_out == '0 && dnpc == '0 && !ebreak && !inst_bad)
        else $error("outputs not at reset values during reset");

endmodule

bind rv_core_ex rv_core_ex_asserts u_asserts (
    .clk       (clk),
    .rst       (rst),
    .in_ready  (in_ready),
    .idu_valid (idu_valid),
    .exu_ready (exu_ready),
    .exu_valid (exu_valid),
    .dec       (dec),
    .idu_pc    (idu_pc),
    .idu_ops   (idu_ops),
    .ex_out    (ex_out),
    .dnpc      (dnpc),
    .ebreak    (ebreak),
    .inst_bad  (inst_bad)
);

`default_nettype wire

// ==== verif/tb_rv_core_ex.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defines.svh"

module tb_rv_core_ex;

    import rv_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int NUM_INST    = 300;
    localparam int WATCHDOG_NS = (NUM_INST * 40 + 10) * CLK_PERIOD;

    typedef struct packed {
        inst_t    inst;
        word_t    pc;
        operand_t ops;
    } item_t;

    typedef struct packed {
        ex_out_t out;
        word_t   dnpc;
        logic    ebreak;
        logic    inst_bad;
    } predict_t;

    logic     clk = 1'b0;
    logic     rst;
    logic     in_valid;
    logic     in_ready;
    inst_t    inst;
    word_t    pc;
    operand_t ops;
    logic     lsu_ready;
    logic     exu_valid;
    ex_out_t  ex_out;
    word_t    dnpc;
    logic     ebreak;
    logic     inst_bad;

    word_t    lfsr_q = 32'd40;
    item_t    pending[$];  // Accepted, result not yet seen.
    int       results_seen = 0;

    rv_core_ex u_dut (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .inst      (inst),
        .pc        (pc),
        .ops       (ops),
        .lsu_ready (lsu_ready),
        .exu_valid (exu_valid),
        .ex_out    (ex_out),
        .dnpc      (dnpc),
        .ebreak    (ebreak),
        .inst_bad  (inst_bad)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////
    // Random source.
    ////////////////////
    function automatic word_t lfsr_next(input word_t s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1.
    endfunction

    task automatic draw_bits(input int n, output word_t v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // Random fields, then opcode and funct bits forced legal.
    task automatic make_inst(output inst_t w);
        word_t r;
        word_t sel;
        draw_bits(32, r);
        draw_bits(4, sel);
        w = r;
        case (sel % 13)
            0: begin
                w[6:0]   = `RV_OPC_OP;
                w[31:25] = ((w[14:12] == 3'b000 || w[14:12] == 3'b101) && w[30]) ?
                           7'h20 : 7'h00;
            end
            1: begin
                w[6:0] = `RV_OPC_OPIMM;
                if (w[14:12] == 3'b001)
                    w[31:25] = 7'h00;
                else if (w[14:12] == 3'b101)
                    w[31:25] = {1'b0, w[30], 5'b0};
            end
            2: w[6:0] = `RV_OPC_LUI;
            3: w[6:0] = `RV_OPC_AUIPC;
            4: w[6:0] = `RV_OPC_JAL;
            5: begin
                w[6:0]   = `RV_OPC_JALR;
                w[14:12] = 3'b000;
            end
            6: begin
                w[6:0] = `RV_OPC_BRANCH;
                if (w[14:13] == 2'b01)
                    w[14] = 1'b1;  // No branch on 010 or 011.
            end
            7: begin
                w[6:0] = `RV_OPC_LOAD;
                if (w[14:12] == 3'b011 || w[14:13] == 2'b11)
                    w[13] = 1'b0;
            end
            8: begin
                w[6:0] = `RV_OPC_STORE;
                w[14]  = 1'b0;
                if (w[13:12] == 2'b11)
                    w[12] = 1'b0;
            end
            9:  w = 32'h0000_0073;  // ecall.
            10: w = 32'h0010_0073;  // ebreak.
            11: w = 32'h3020_0073;  // mret.
            default: w[6:0] = 7'b0000000;
        endcase
    endtask

    ////////////////////
    // Reference model.
    ////////////////////
    function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
                                      input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic predict_t ref_execute(input inst_t w, input word_t pc_v,
                                             input operand_t o);
        predict_t   e;
        logic [2:0] f3;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        word_t      seq;
        word_t      target;
        logic       taken;
        f3     = w[14:12];
        imm_i  = {{20{w[31]}}, w[31:20]};
        imm_s  = {{20{w[31]}}, w[31:25], w[11:7]};
        imm_b  = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u  = {w[31:12], 12'b0};
        imm_j  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        seq    = pc_v + 32'd4;
        target = pc_v + imm_b;
        taken  = 1'b0;
        e      = '0;
        e.out.store_data = o.src2;
        e.dnpc = seq;
        case (w[6:0])
            `RV_OPC_OP:    e.out.result = alu_ref(f3, w[30], o.src1, o.src2);
            `RV_OPC_OPIMM: e.out.result = alu_ref(f3, f3 == 3'b101 && w[30], o.src1, imm_i);
            `RV_OPC_LUI:   e.out.result = imm_u;
            `RV_OPC_AUIPC: e.out.result = pc_v + imm_u;
            `RV_OPC_JAL: begin
                e.out.result = seq;
                e.dnpc = (pc_v + imm_j) & 32'hffff_fffe;
            end
            `RV_OPC_JALR: begin
                e.out.result = seq;
                e.dnpc = (o.src1 + imm_i) & 32'hffff_fffe;
            end
            `RV_OPC_BRANCH: begin
                case (f3)
                    3'b000:  taken = o.src1 == o.src2;
                    3'b001:  taken = o.src1 != o.src2;
                    3'b100:  taken = $signed(o.src1) < $signed(o.src2);
                    3'b101:  taken = $signed(o.src1) >= $signed(o.src2);
                    3'b110:  taken = o.src1 < o.src2;
                    default: taken = o.src1 >= o.src2;
                endcase
                e.out.result = target;
                if (taken)
                    e.dnpc = target;
            end
            `RV_OPC_LOAD:  e.out.result = o.src1 + imm_i;
            `RV_OPC_STORE: e.out.result = o.src1 + imm_s;
            `RV_OPC_SYSTEM: begin
                case (w)
                    32'h0000_0073: e.dnpc = o.mtvec;
                    32'h0010_0073: e.ebreak = 1'b1;
                    32'h3020_0073: e.dnpc = o.mepc;
                    default:       e.inst_bad = 1'b1;
                endcase
            end
            default: e.inst_bad = 1'b1;
        endcase
        return e;
    endfunction

    ////////////////////
    // Checks.
    ////////////////////
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_out(input string name, input ex_out_t exp, input ex_out_t act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            abort_run($sformatf("FAIL %s expected %b actual %b", name, exp, act));
    endtask

    // Outputs and handshakes are stable at the falling edge.
    always @(negedge clk) begin
        item_t    item;
        predict_t exp;
        string    tag;
        if (rst && exu_valid) begin
            if (pending.size() == 0) begin
                abort_run("A result came out with no instruction outstanding.");
            end else begin
                item = pending.pop_front();
                exp  = ref_execute(item.inst, item.pc, item.ops);
                tag  = $sformatf("inst%0d_%h", results_seen, item.inst);
                check_out({tag, "_ex_out"}, exp.out, ex_out);
                check_word({tag, "_dnpc"}, exp.dnpc, dnpc);
                check_flag({tag, "_ebreak"}, exp.ebreak, ebreak);
                check_flag({tag, "_inst_bad"}, exp.inst_bad, inst_bad);
                results_seen++;
            end
        end
        if (rst && in_valid && in_ready) begin
            item.inst = inst;
            item.pc   = pc;
            item.ops  = ops;
            pending.push_back(item);
        end
    end

    ////////////////////
    // Stimulus.
    ////////////////////
    initial begin
        word_t bits;
        lsu_ready = 1'b1;
        wait (rst === 1'b0);
        wait (rst === 1'b1);
        forever begin
            @(negedge clk);
            draw_bits(2, bits);
            @(posedge clk);
            #1;
            lsu_ready = bits[1:0] != 2'b00;  // Stall one cycle in four.
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout, no result arrived within %0d ns.", WATCHDOG_NS));
    end

    initial begin
        int       n;
        word_t    r;
        inst_t    w;
        operand_t op_v;
        rst      = 1'b1;
        in_valid = 1'b0;
        inst     = '0;
        pc       = '0;
        ops      = '0;
        #1 rst = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b1;

        repeat (4) begin
            @(negedge clk);
            check_flag("idle_in_ready", 1'b1, in_ready);
            check_flag("idle_exu_valid", 1'b0, exu_valid);
        end
        @(posedge clk);
        #1;

        for (n = 0; n < NUM_INST; n++) begin
            draw_bits(2, r);
            if (r[1]) begin
                repeat (r[0] ? 2 : 1) begin
                    @(posedge clk);
                    #1;
                end
            end
            make_inst(w);
            draw_bits(32, r);
            pc = {r[31:2], 2'b00};
            draw_bits(32, r);
            op_v.src1 = r;
            draw_bits(32, r);
            op_v.src2 = r;
            draw_bits(32, r);
            op_v.mtvec = r;
            draw_bits(32, r);
            op_v.mepc = r;
            draw_bits(2, r);
            if (r[1:0] == 2'b00)
                op_v.src2 = op_v.src1;  // Equal operands for branches.
            inst     = w;
            ops      = op_v;
            in_valid = 1'b1;
            do
                @(negedge clk);
            while (!in_ready);
            @(posedge clk);
            #1;
            in_valid = 1'b0;
        end

        while (results_seen < NUM_INST)
            @(negedge clk);
        repeat (6) @(negedge clk);  // Late extra results still reach the checker.
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
